// ==== source/bridge_cfg.svh ====
// widths, memory size and RAM timing for the chip to memory bridge
// include wherever a width or the RAM depth is needed
`ifndef BRIDGE_CFG_SVH
`define BRIDGE_CFG_SVH

// ==============================
// data path
// ==============================

// one chip word, also one memory word
`define BRIDGE_DATA_W 64

// ==============================
// memory
// ==============================

// word address, byte address adds 3 low bits
`define BRIDGE_ADDR_W 10

// full array, address wraps at the top
`define BRIDGE_MEM_DEPTH (1 << `BRIDGE_ADDR_W)

// cycles between strobe and ack, stands in for board DDR
`define BRIDGE_WAIT_STATES 2

`endif

// ==== source/bridge_pkg.sv ====
// shared types of the bridge: data and address vectors, decode states
// import inside module bodies, use scoped names in port lists
`default_nettype none

`include "bridge_cfg.svh"

package bridge_pkg;

    // ==============================
    // vectors
    // ==============================

    // chip and memory data word
    typedef logic [`BRIDGE_DATA_W-1:0] data_t;

    // word address into the RAM
    typedef logic [`BRIDGE_ADDR_W-1:0] word_addr_t;

    // wishbone byte address, word address shifted by 3
    typedef logic [`BRIDGE_ADDR_W+2:0] wb_addr_t;

    // ==============================
    // decode states
    // ==============================

    typedef enum logic [2:0] {
        MODE_IDLE  = 3'd0,  // waiting for a command pulse
        MODE_CMD   = 3'd1,  // ready for the command word
        MODE_WRITE = 3'd2,  // chip streams words into memory
        MODE_READ  = 3'd3,  // memory streams words to chip
        MODE_DRAIN = 3'd4   // end seen, last cycle finishing
    } xfer_mode_e;

endpackage

`default_nettype wire

// ==== source/cmd_decode.sv ====
// chip-side transfer FSM: takes the command word, drives ready and the
// per-word accept, load and flush strobes for the rest of the bridge
`default_nettype none

`include "bridge_cfg.svh"

module cmd_decode (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     i_cmd_vld,
    input  bridge_pkg::data_t       i_dat,
    input  wire                     i_dat_vld,
    input  wire                     i_busy,
    output logic                    o_dat_rdy,
    output bridge_pkg::xfer_mode_e  o_mode,
    output bridge_pkg::word_addr_t  o_base_addr,
    output logic                    o_load,
    output logic                    o_wr_accept,
    output logic                    o_flush
);

    import bridge_pkg::*;

    xfer_mode_e mode_q;
    xfer_mode_e mode_d;
    logic       dat_take;

    // ==============================
    // handshake
    // ==============================

    // ready in cmd, or in write while no cycle is open
    // write gets back-pressure for every word this way
    assign o_dat_rdy = (mode_q == MODE_CMD) ||
                       ((mode_q == MODE_WRITE) && !i_busy);

    // word moves on this edge
    assign dat_take = i_dat_vld && o_dat_rdy;

    // command word taken, execute loads its counter
    assign o_load = (mode_q == MODE_CMD) && dat_take;

    // base address sits above the direction bit
    assign o_base_addr = i_dat[1 +: `BRIDGE_ADDR_W];

    // one pulse per write word handed to execute
    assign o_wr_accept = (mode_q == MODE_WRITE) && dat_take;

    // chip ends a read, prefetched word is dropped
    assign o_flush = (mode_q == MODE_READ) && i_cmd_vld;

    // ==============================
    // transfer FSM
    // ==============================

    always_comb begin
        mode_d = mode_q;
        case (mode_q)
            MODE_IDLE: begin
                if (i_cmd_vld) begin
                    mode_d = MODE_CMD;
                end
            end
            MODE_CMD: begin
                // bit 0 set means chip writes into memory
                if (dat_take) begin
                    mode_d = i_dat[0] ? MODE_WRITE : MODE_READ;
                end
            end
            MODE_WRITE, MODE_READ: begin
                if (i_cmd_vld) begin
                    mode_d = MODE_DRAIN;
                end
            end
            MODE_DRAIN: begin
                // let an open wishbone cycle finish first
                if (!i_busy) begin
                    mode_d = MODE_IDLE;
                end
            end
            default: mode_d = MODE_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q <= MODE_IDLE;
        end else begin
            mode_q <= mode_d;
        end
    end

    assign o_mode = mode_q;

endmodule

`default_nettype wire

// ==== source/wb_execute.sv ====
// wishbone classic master: word address counter, write data register,
// one cycle per write word and read prefetch while the buffer has room
`default_nettype none

`include "bridge_cfg.svh"

module wb_execute (
    input  wire                     clk,
    input  wire                     rst_n,
    input  bridge_pkg::xfer_mode_e  i_mode,
    input  bridge_pkg::word_addr_t  i_base_addr,
    input  wire                     i_load,
    input  wire                     i_wr_accept,
    input  bridge_pkg::data_t       i_wr_data,
    input  wire                     i_buf_full,
    output logic                    o_busy,
    output logic                    o_rd_done,
    output bridge_pkg::data_t       o_rd_data,
    output logic                    o_wb_cyc,
    output logic                    o_wb_stb,
    output logic                    o_wb_we,
    output bridge_pkg::wb_addr_t    o_wb_adr,
    output bridge_pkg::data_t       o_wb_dat,
    input  bridge_pkg::data_t       i_wb_dat,
    input  wire                     i_wb_ack
);

    import bridge_pkg::*;

    word_addr_t addr_q;
    data_t      wr_data_q;
    logic       cyc_q;
    logic       we_q;
    logic       rd_start;
    logic       cyc_end;

    // ==============================
    // cycle control
    // ==============================

    // prefetch only with room in the result buffer
    assign rd_start = (i_mode == MODE_READ) && !cyc_q && !i_buf_full;

    // ack sampled, cycle closes on this edge
    assign cyc_end = cyc_q && i_wb_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc_q <= 1'b0;
            we_q  <= 1'b0;
        end else if (cyc_end) begin
            cyc_q <= 1'b0;
        end else if (i_wr_accept) begin
            cyc_q <= 1'b1;
            we_q  <= 1'b1;
        end else if (rd_start) begin
            cyc_q <= 1'b1;
            we_q  <= 1'b0;
        end
    end

    // payload, held until ack
    always_ff @(posedge clk) begin
        if (i_wr_accept) begin
            wr_data_q <= i_wr_data;
        end
    end

    // ==============================
    // word address counter
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (i_load) begin
            addr_q <= i_base_addr;
        end else if (cyc_end) begin
            // wrap at top of memory
            if (addr_q == word_addr_t'(`BRIDGE_MEM_DEPTH - 1)) begin
                addr_q <= '0;
            end else begin
                addr_q <= addr_q + 1'b1;
            end
        end
    end

    // ==============================
    // outputs
    // ==============================

    assign o_wb_cyc = cyc_q;
    assign o_wb_stb = cyc_q;
    assign o_wb_we  = we_q;
    // byte address, 8 bytes per word
    assign o_wb_adr = {addr_q, 3'b000};
    assign o_wb_dat = wr_data_q;
    assign o_busy   = cyc_q;

    // a read that lands after the chip ended the transfer is dropped here
    assign o_rd_done = cyc_end && !we_q && (i_mode == MODE_READ);
    assign o_rd_data = i_wb_dat;

endmodule

`default_nettype wire

// ==== source/rd_result.sv ====
// one-word read buffer between the wishbone master and the chip
// holds the word stable until the chip takes it, flush empties it
`default_nettype none

module rd_result (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 i_rd_done,
    input  bridge_pkg::data_t   i_rd_data,
    input  wire                 i_flush,
    input  wire                 i_dat_rdy,
    output bridge_pkg::data_t   o_dat,
    output logic                o_dat_vld,
    output logic                o_buf_full
);

    import bridge_pkg::*;

    data_t buf_q;
    logic  full_q;

    // ==============================
    // occupancy
    // ==============================

    // flush wins over a read landing the same edge
    // new word only arrives while empty
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (i_flush) begin
            full_q <= 1'b0;
        end else if (i_rd_done) begin
            full_q <= 1'b1;
        end else if (full_q && i_dat_rdy) begin
            // chip took the word
            full_q <= 1'b0;
        end
    end

    // ==============================
    // word store
    // ==============================

    always_ff @(posedge clk) begin
        if (i_rd_done) begin
            buf_q <= i_rd_data;
        end
    end

    // valid and full are one flag
    assign o_dat      = buf_q;
    assign o_dat_vld  = full_q;
    assign o_buf_full = full_q;

endmodule

`default_nettype wire

// ==== source/wb_ram.sv ====
// wishbone classic slave RAM, word addressed, fixed wait states
// before ack; access and ack happen on the same edge
`default_nettype none

`include "bridge_cfg.svh"

module wb_ram (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     i_wb_cyc,
    input  wire                     i_wb_stb,
    input  wire                     i_wb_we,
    input  bridge_pkg::wb_addr_t    i_wb_adr,
    input  bridge_pkg::data_t       i_wb_dat,
    output bridge_pkg::data_t       o_wb_dat,
    output logic                    o_wb_ack
);

    import bridge_pkg::*;

    localparam int WAIT_W = $clog2(`BRIDGE_WAIT_STATES + 1);

    data_t              mem [`BRIDGE_MEM_DEPTH];
    logic [WAIT_W-1:0]  wait_q;
    logic               req;
    logic               hit;
    word_addr_t         word_adr;

    // ==============================
    // wait counter
    // ==============================

    // live request, not yet acked
    assign req = i_wb_cyc && i_wb_stb && !o_wb_ack;

    // last wait state done
    assign hit = req && (wait_q == WAIT_W'(`BRIDGE_WAIT_STATES));

    // low 3 bits are the byte lane
    assign word_adr = i_wb_adr[3 +: `BRIDGE_ADDR_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_q   <= '0;
            o_wb_ack <= 1'b0;
        end else if (hit) begin
            wait_q   <= '0;
            o_wb_ack <= 1'b1;
        end else if (req) begin
            wait_q   <= wait_q + 1'b1;
        end else begin
            // ack is a single cycle
            o_wb_ack <= 1'b0;
        end
    end

    // ==============================
    // array
    // ==============================

    always_ff @(posedge clk) begin
        if (hit && i_wb_we) begin
            mem[word_adr] <= i_wb_dat;
        end
        if (hit && !i_wb_we) begin
            o_wb_dat <= mem[word_adr];
        end
    end

endmodule

`default_nettype wire

// ==== source/chip_mem_bridge.sv ====
// top of the chip to memory bridge: decode, wishbone execute, read
// result and the wait-state RAM standing in for board memory
`default_nettype none

module chip_mem_bridge (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 i_cmd_vld,
    input  bridge_pkg::data_t   i_dat,
    input  wire                 i_dat_vld,
    output logic                o_dat_rdy,
    output bridge_pkg::data_t   o_dat,
    output logic                o_dat_vld,
    input  wire                 i_dat_rdy
);

    import bridge_pkg::*;

    // decode to execute
    xfer_mode_e mode;
    word_addr_t base_addr;
    logic       load;
    logic       wr_accept;
    logic       flush;

    // execute status and read path
    logic       busy;
    logic       rd_done;
    data_t      rd_data;
    logic       buf_full;

    // wishbone between master and RAM
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    wb_addr_t   wb_adr;
    data_t      wb_dat_w;
    data_t      wb_dat_r;
    logic       wb_ack;

    // ==============================
    // stages
    // ==============================

    cmd_decode u_cmd_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_cmd_vld   (i_cmd_vld),
        .i_dat       (i_dat),
        .i_dat_vld   (i_dat_vld),
        .i_busy      (busy),
        .o_dat_rdy   (o_dat_rdy),
        .o_mode      (mode),
        .o_base_addr (base_addr),
        .o_load      (load),
        .o_wr_accept (wr_accept),
        .o_flush     (flush)
    );

    // write data comes straight off the chip bus
    wb_execute u_wb_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_mode      (mode),
        .i_base_addr (base_addr),
        .i_load      (load),
        .i_wr_accept (wr_accept),
        .i_wr_data   (i_dat),
        .i_buf_full  (buf_full),
        .o_busy      (busy),
        .o_rd_done   (rd_done),
        .o_rd_data   (rd_data),
        .o_wb_cyc    (wb_cyc),
        .o_wb_stb    (wb_stb),
        .o_wb_we     (wb_we),
        .o_wb_adr    (wb_adr),
        .o_wb_dat    (wb_dat_w),
        .i_wb_dat    (wb_dat_r),
        .i_wb_ack    (wb_ack)
    );

    rd_result u_rd_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rd_done  (rd_done),
        .i_rd_data  (rd_data),
        .i_flush    (flush),
        .i_dat_rdy  (i_dat_rdy),
        .o_dat      (o_dat),
        .o_dat_vld  (o_dat_vld),
        .o_buf_full (buf_full)
    );

    // ==============================
    // memory
    // ==============================

    wb_ram u_wb_ram (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_dat_w),
        .o_wb_dat (wb_dat_r),
        .o_wb_ack (wb_ack)
    );

endmodule

`default_nettype wire

// ==== test/bridge_sva.sv ====
// wishbone and chip handshake rules bound into the bridge top level
`default_nettype none

module bridge_sva (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     wb_cyc,
    input  wire                     wb_stb,
    input  wire                     wb_we,
    input  wire                     wb_ack,
    input  bridge_pkg::wb_addr_t    wb_adr,
    input  bridge_pkg::data_t       wb_dat_w,
    input  bridge_pkg::xfer_mode_e  mode,
    input  wire                     o_dat_vld
);
    timeunit 1ns;
    timeprecision 1ps;

    import bridge_pkg::*;

    // ack answers a live strobe and the master closes the cycle on it
    a_ack_end: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb) ##1 (!wb_ack && !wb_cyc))
        else $error("wishbone ack outside a strobe or cycle not closed after ack");

    // open cycle without ack keeps address and direction
    a_adr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_cyc && !wb_ack) |=> (wb_cyc && $stable(wb_adr) && $stable(wb_we)))
        else $error("wishbone address or direction moved before ack");

    a_dat_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_cyc && wb_we && !wb_ack) |=> $stable(wb_dat_w))
        else $error("wishbone write data moved before ack");

    // read data only offered during a read
    a_vld_read: assert property (@(posedge clk) disable iff (!rst_n)
        o_dat_vld |-> (mode == MODE_READ))
        else $error("read valid high outside a read transfer");

endmodule

bind chip_mem_bridge bridge_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_ack    (wb_ack),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .mode      (mode),
    .o_dat_vld (o_dat_vld)
);

`default_nettype wire

// ==== test/bridge_checker.sv ====
// watches the chip-side ports and keeps its own memory model
// checks every read word and reports once per finished test
`default_nettype none

`include "bridge_cfg.svh"

module bridge_checker (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire [127:0]         i_test_name,
    input  wire                 i_cmd_vld,
    input  bridge_pkg::data_t   i_wr_dat,
    input  wire                 i_wr_vld,
    input  wire                 i_wr_rdy,
    input  bridge_pkg::data_t   i_rd_dat,
    input  wire                 i_rd_vld,
    input  wire                 i_rd_rdy,
    output logic [31:0]         o_tests,
    output logic [31:0]         o_errors
);
    timeunit 1ns;
    timeprecision 1ps;

    import bridge_pkg::*;

    typedef enum logic [1:0] {CK_IDLE, CK_CMD, CK_WRITE, CK_READ} ck_state_e;

    data_t      model [`BRIDGE_MEM_DEPTH];
    ck_state_e  state;
    word_addr_t addr;
    int         words;
    logic       bad_data;
    logic       bad_hold;
    data_t      first_exp;
    data_t      first_act;
    logic       held_vld;
    data_t      held;

    // next word address with wrap at the top of memory
    function automatic word_addr_t step_addr(input word_addr_t a);
        return word_addr_t'((int'(a) + 1) % `BRIDGE_MEM_DEPTH);
    endfunction

    task automatic close_test();
        if (bad_data) begin
            $display("Fail %0s expected %h actual %h", i_test_name, first_exp, first_act);
        end else if (bad_hold) begin
            $display("Fail %0s: read data changed or dropped while waiting for ready",
                     i_test_name);
        end else begin
            $display("ok   %0s %0d words", i_test_name, words);
        end
        if (bad_data || bad_hold) begin
            o_errors++;
        end
        o_tests++;
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= CK_IDLE;
            held_vld <= 1'b0;
            o_tests  = '0;
            o_errors = '0;
        end else begin
            // word on offer must stay put until taken
            if (held_vld && (!i_rd_vld || i_rd_dat !== held)) begin
                bad_hold = 1'b1;
            end
            held_vld <= (state == CK_READ) && i_rd_vld && !i_rd_rdy && !i_cmd_vld;
            held     <= i_rd_dat;

            case (state)
                CK_IDLE: begin
                    if (i_cmd_vld) begin
                        state    <= CK_CMD;
                        words    = 0;
                        bad_data = 1'b0;
                        bad_hold = 1'b0;
                    end
                end
                CK_CMD: begin
                    if (i_wr_vld && i_wr_rdy) begin
                        addr  = i_wr_dat[1 +: `BRIDGE_ADDR_W];
                        state <= i_wr_dat[0] ? CK_WRITE : CK_READ;
                    end
                end
                CK_WRITE: begin
                    if (i_cmd_vld) begin
                        close_test();
                        state <= CK_IDLE;
                    end else if (i_wr_vld && i_wr_rdy) begin
                        model[addr] = i_wr_dat;
                        addr  = step_addr(addr);
                        words++;
                    end
                end
                default: begin
                    if (i_cmd_vld) begin
                        close_test();
                        state <= CK_IDLE;
                    end else if (i_rd_vld && i_rd_rdy) begin
                        if (i_rd_dat !== model[addr] && !bad_data) begin
                            bad_data  = 1'b1;
                            first_exp = model[addr];
                            first_act = i_rd_dat;
                        end
                        addr = step_addr(addr);
                        words++;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_bridge.sv ====
// testbench top for the chip to memory bridge
// runs the tests in test/bridge_input.txt and prints the closing verdict
`default_nettype none

`include "bridge_cfg.svh"

module tb_bridge;
    timeunit 1ns;
    timeprecision 1ps;

    import bridge_pkg::*;

    localparam int PERIOD    = 20;
    localparam int MAX_TESTS = 32;

    logic           clk;
    logic           rst_n;
    logic           i_cmd_vld;
    data_t          i_dat;
    logic           i_dat_vld;
    logic           i_dat_rdy;
    logic           o_dat_rdy;
    data_t          o_dat;
    logic           o_dat_vld;
    logic [127:0]   test_name;
    logic [31:0]    chk_tests;
    logic [31:0]    chk_errors;

    // test table from the input file
    logic [127:0]   names [MAX_TESTS];
    int             dirs [MAX_TESTS];
    int             bases [MAX_TESTS];
    int             counts [MAX_TESTS];
    int             gaps [MAX_TESTS];
    int             n_tests;
    int             tb_errors;
    longint         limit_ns;
    logic [31:0]    lfsr;

    chip_mem_bridge u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_cmd_vld (i_cmd_vld),
        .i_dat     (i_dat),
        .i_dat_vld (i_dat_vld),
        .o_dat_rdy (o_dat_rdy),
        .o_dat     (o_dat),
        .o_dat_vld (o_dat_vld),
        .i_dat_rdy (i_dat_rdy)
    );

    bridge_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_test_name (test_name),
        .i_cmd_vld   (i_cmd_vld),
        .i_wr_dat    (i_dat),
        .i_wr_vld    (i_dat_vld),
        .i_wr_rdy    (o_dat_rdy),
        .i_rd_dat    (o_dat),
        .i_rd_vld    (o_dat_vld),
        .i_rd_rdy    (i_dat_rdy),
        .o_tests     (chk_tests),
        .o_errors    (chk_errors)
    );

    always #(PERIOD / 2) clk = ~clk;

    // ==============================
    // random source
    // ==============================

    // galois form with taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic take_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    function automatic data_t take_word();
        data_t w;
        w = '0;
        for (int i = 0; i < `BRIDGE_DATA_W; i++) begin
            w = {w[`BRIDGE_DATA_W-2:0], take_bit()};
        end
        return w;
    endfunction

    // ==============================
    // chip-side driving on falling edges
    // ==============================

    task automatic pulse_cmd();
        i_cmd_vld = 1'b1;
        @(negedge clk);
        i_cmd_vld = 1'b0;
    endtask

    // ready depends only on bridge registers and is settled at the falling edge
    task automatic send_word(input data_t w);
        logic taken;
        i_dat     = w;
        i_dat_vld = 1'b1;
        do begin
            taken = o_dat_rdy;
            @(negedge clk);
        end while (!taken);
        i_dat_vld = 1'b0;
    endtask

    task automatic run_write(input int base, input int count, input int gap);
        pulse_cmd();
        send_word(data_t'({base[`BRIDGE_ADDR_W-1:0], 1'b1}));
        for (int i = 0; i < count; i++) begin
            if (gap != 0) begin
                while (take_bit()) begin
                    @(negedge clk);
                end
            end
            send_word(take_word());
        end
        pulse_cmd();
    endtask

    task automatic run_read(input int base, input int count, input int gap);
        int   got;
        logic taken;
        got = 0;
        pulse_cmd();
        send_word(data_t'({base[`BRIDGE_ADDR_W-1:0], 1'b0}));
        while (got < count) begin
            i_dat_rdy = (gap != 0) ? take_bit() : 1'b1;
            taken = o_dat_vld && i_dat_rdy;
            @(negedge clk);
            if (taken) begin
                got++;
            end
        end
        // hold off until the next word sits in the buffer
        i_dat_rdy = 1'b0;
        while (!o_dat_vld) begin
            @(negedge clk);
        end
        // ending the read now must discard the buffered word
        pulse_cmd();
    endtask

    task automatic load_tests();
        int           fd;
        int           n;
        string        line;
        logic [127:0] nm;
        int           d;
        int           b;
        int           c;
        int           g;
        n_tests = 0;
        fd = $fopen("test/bridge_input.txt", "r");
        if (fd == 0) begin
            $display("stimulus file test/bridge_input.txt could not be opened");
            tb_errors++;
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %d %d %d %d", nm, d, b, c, g);
                    if (n == 5) begin
                        names[n_tests]  = nm;
                        dirs[n_tests]   = d;
                        bases[n_tests]  = b;
                        counts[n_tests] = c;
                        gaps[n_tests]   = g;
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ==============================
    // watchdog
    // ==============================

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("watchdog expired, a test did not finish in time");
        $display("Test FAILED");
        $finish;
    end

    // ==============================
    // main sequence
    // ==============================

    initial begin
        longint words;
        clk       = 1'b0;
        rst_n     = 1'b0;
        i_cmd_vld = 1'b0;
        i_dat     = '0;
        i_dat_vld = 1'b0;
        i_dat_rdy = 1'b0;
        test_name = '0;
        tb_errors = 0;
        limit_ns  = 0;
        lfsr      = 32'hd843;
        load_tests();
        words = 0;
        for (int t = 0; t < n_tests; t++) begin
            words += counts[t];
        end
        limit_ns = (words * (`BRIDGE_WAIT_STATES + 4) + n_tests * 100 + 1000) * PERIOD;

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        // nothing may be offered before the first command
        if (o_dat_rdy !== 1'b0 || o_dat_vld !== 1'b0) begin
            $display("ready or read valid is high after reset without a command");
            tb_errors++;
        end

        for (int t = 0; t < n_tests; t++) begin
            test_name = names[t];
            if (dirs[t] != 0) begin
                run_write(bases[t], counts[t], gaps[t]);
            end else begin
                run_read(bases[t], counts[t], gaps[t]);
            end
            // drain finishes before the next command pulse
            repeat (10) @(negedge clk);
        end

        $display("tests %0d of %0d, failed %0d, other errors %0d",
                 chk_tests, n_tests, chk_errors, tb_errors);
        if (n_tests > 0 && chk_tests == n_tests && chk_errors == 0 && tb_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/bridge_input.txt ====
# name  direction(1 write, 0 read)  base word address  word count  gap mode(1 random gaps)
# reads only cover words written by an earlier test
wr_seq 1 0 16 0
rd_seq 0 0 16 0
rd_backpress 0 0 16 1
wr_gaps 1 64 24 1
rd_gaps 0 64 24 0
wr_wrap 1 1018 12 0
rd_wrap 0 1018 12 1
rd_early 0 64 5 0
rd_other 0 4 8 0
rd_early_bp 0 70 3 1
rd_after 0 1020 6 0

// ==== filelist.f ====
+incdir+source
source/bridge_pkg.sv
source/cmd_decode.sv
source/wb_execute.sv
source/rd_result.sv
source/wb_ram.sv
source/chip_mem_bridge.sv
test/bridge_sva.sv
test/bridge_checker.sv
test/tb_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_bridge -f filelist.f -o tb_bridge

./obj_dir/tb_bridge > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
grep -q "Test OK" sim.log
